// ==== design/ui_pkg.sv ====
/*
 * Button-side types for the coffee machine menu controller.
 * One struct carries the four front-panel buttons. It is used for
 * raw levels, debounced levels and press pulses alike.
 */

package ui_pkg;

    // ==================================================
    // Button bundle
    // ==================================================

    // Front-panel buttons
    typedef struct packed {
        logic cancel;
        logic left;
        logic right;
        logic select;
    } btn_set_t;

    // ==================================================
    // Timer widths
    // ==================================================

    // Debounce counter, room for 20 ms at 50 MHz
    typedef logic [19:0] debounce_cnt_t;

    // Combo hold timer, room for several seconds at 50 MHz
    typedef logic [31:0] combo_cnt_t;

endpackage

// ==== design/brew_pkg.sv ====
/*
 * Menu-side types for the coffee machine menu controller.
 * Holds the menu state encoding, the choice index type with its
 * counts and reset values, the selection bundle and the status bundle.
 */

package brew_pkg;

    // ==================================================
    // Menu states
    // ==================================================

    typedef enum logic [3:0] {
        splash        = 4'd0,
        check_errors  = 4'd1,
        coffee_select = 4'd2,
        drink_select  = 4'd3,
        size_select   = 4'd4,
        confirm       = 4'd5,
        brewing       = 4'd6,
        complete      = 4'd7,
        settings      = 4'd8,
        error         = 4'd9
    } menu_state_e;

    // ==================================================
    // Choices
    // ==================================================

    // Shared by all selection wheels
    typedef logic [2:0] item_idx_t;

    // Number of entries per page
    localparam int NUM_COFFEE_BINS = 2;
    localparam int NUM_DRINKS      = 5;
    localparam int NUM_SIZES       = 3;

    // Bin 0, black coffee, 12 oz
    localparam int DEFAULT_BIN   = 0;
    localparam int DEFAULT_DRINK = 0;
    localparam int DEFAULT_SIZE  = 1;

    // Current customer selection
    typedef struct packed {
        logic [2:0] bin;
        logic [2:0] drink;
        logic [1:0] size;
    } brew_sel_t;

    // Status levels from the rest of the machine
    typedef struct packed {
        logic system_ready;
        logic brewing_active;
        logic error_present;
        logic recipe_valid;
        logic can_make_coffee;
    } machine_status_t;

endpackage

// ==== design/button_debouncer.sv ====
/*
 * Single push-button debouncer.
 * The stored level follows the raw input only after the input has
 * disagreed with it for DEBOUNCE_CYCLES clock edges in a row.
 */

`timescale 1ns/1ps

module button_debouncer #(
    parameter int DEBOUNCE_CYCLES = 1_000_000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic raw,
    output logic level
);

    // Last count value before the level flips
    localparam ui_pkg::debounce_cnt_t CNT_LAST =
        ui_pkg::debounce_cnt_t'(DEBOUNCE_CYCLES - 1);

    // Consecutive disagreeing cycles so far
    ui_pkg::debounce_cnt_t cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            level <= 1'b0;
        end else if (raw == level) begin
            // Input agrees, start over
            cnt <= '0;
        end else if (cnt >= CNT_LAST) begin
            // Stable long enough
            level <= raw;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== design/button_frontend.sv ====
/*
 * Button front end.
 * Debounces the four raw buttons and turns each rising debounced
 * level into a one-cycle press pulse.
 */

`timescale 1ns/1ps

module button_frontend #(
    parameter int DEBOUNCE_CYCLES = 1_000_000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  ui_pkg::btn_set_t raw,
    output ui_pkg::btn_set_t held,
    output ui_pkg::btn_set_t pressed
);

    // Debounced levels one cycle late
    ui_pkg::btn_set_t held_d;

    // ==================================================
    // Debouncers
    // ==================================================

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_cancel (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (raw.cancel),
        .level (held.cancel)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_left (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (raw.left),
        .level (held.left)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_right (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (raw.right),
        .level (held.right)
    );

    button_debouncer #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_db_select (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (raw.select),
        .level (held.select)
    );

    // ==================================================
    // Rising-edge detect
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_d <= '0;
        end else begin
            held_d <= held;
        end
    end

    // High now, low one cycle earlier
    assign pressed = ui_pkg::btn_set_t'(held & ~held_d);

endmodule

// ==== design/settings_combo_detector.sv ====
/*
 * Settings combo detector.
 * Times a left+right+select hold and raises the settings request once
 * the hold has lasted COMBO_CYCLES edges. The request stays up until
 * one of the three buttons is let go.
 */

`timescale 1ns/1ps

module settings_combo_detector #(
    parameter int COMBO_CYCLES = 100_000_000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  ui_pkg::btn_set_t held,
    output logic             combo_request
);

    localparam ui_pkg::combo_cnt_t CNT_LAST = ui_pkg::combo_cnt_t'(COMBO_CYCLES - 1);

    ui_pkg::combo_cnt_t timer;
    logic               all_held;

    // Cancel plays no part in the combo
    assign all_held = held.left & held.right & held.select;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer         <= '0;
            combo_request <= 1'b0;
        end else if (!all_held) begin
            // Any release restarts the hold
            timer         <= '0;
            combo_request <= 1'b0;
        end else if (timer >= CNT_LAST) begin
            // Saturate and keep requesting
            combo_request <= 1'b1;
        end else begin
            timer <= timer + 1'b1;
        end
    end

endmodule

// ==== design/selection_wheel.sv ====
/*
 * Wrap-around selection wheel.
 * While its menu page is active, left steps the index down and right
 * steps it up, wrapping over 0 .. NUM_ITEMS-1. Left wins a tie.
 */

`timescale 1ns/1ps

module selection_wheel #(
    parameter int NUM_ITEMS  = 2,
    parameter int RESET_ITEM = 0
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                active,
    input  logic                step_left,
    input  logic                step_right,
    output brew_pkg::item_idx_t value
);

    localparam brew_pkg::item_idx_t FIRST_ITEM = '0;
    localparam brew_pkg::item_idx_t LAST_ITEM  = brew_pkg::item_idx_t'(NUM_ITEMS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            value <= brew_pkg::item_idx_t'(RESET_ITEM);
        end else if (active) begin
            if (step_left) begin
                // Down, wrap to the last entry
                if (value == FIRST_ITEM) begin
                    value <= LAST_ITEM;
                end else begin
                    value <= value - 1'b1;
                end
            end else if (step_right) begin
                // Up, wrap to the first entry
                if (value >= LAST_ITEM) begin
                    value <= FIRST_ITEM;
                end else begin
                    value <= value + 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/menu_fsm.sv ====
/*
 * Menu state machine of the coffee machine front panel.
 * Walks splash, error check, the three choice pages, confirm, brewing
 * and complete, with side exits to error and settings. Drives the page
 * enables of the wheels and the start-brewing and settings pulses.
 */

`timescale 1ns/1ps

module menu_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ui_pkg::btn_set_t          pressed,
    input  logic                      combo_request,
    input  brew_pkg::machine_status_t status,
    output brew_pkg::menu_state_e     menu_state,
    output logic                      bin_active,
    output logic                      drink_active,
    output logic                      size_active,
    output logic                      start_brewing,
    output logic                      enter_settings
);

    brew_pkg::menu_state_e next_state;
    logic                  any_press;

    assign any_press = pressed.cancel | pressed.left | pressed.right | pressed.select;

    // ==================================================
    // State register
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            menu_state <= brew_pkg::splash;
        end else begin
            menu_state <= next_state;
        end
    end

    // ==================================================
    // Next state
    // ==================================================

    always_comb begin
        next_state = menu_state;
        case (menu_state)
            brew_pkg::splash: begin
                if (any_press) begin
                    next_state = brew_pkg::check_errors;
                end else if (combo_request) begin
                    next_state = brew_pkg::settings;
                end
            end
            brew_pkg::check_errors: begin
                // Waits here until status settles
                if (status.error_present) begin
                    next_state = brew_pkg::error;
                end else if (status.system_ready && status.can_make_coffee) begin
                    next_state = brew_pkg::coffee_select;
                end else if (!status.can_make_coffee) begin
                    next_state = brew_pkg::error;
                end
            end
            brew_pkg::coffee_select: begin
                if (pressed.select) begin
                    next_state = brew_pkg::drink_select;
                end else if (pressed.cancel) begin
                    next_state = brew_pkg::splash;
                end else if (combo_request) begin
                    next_state = brew_pkg::settings;
                end
            end
            brew_pkg::drink_select: begin
                if (pressed.select) begin
                    next_state = brew_pkg::size_select;
                end else if (pressed.cancel) begin
                    next_state = brew_pkg::coffee_select;
                end else if (combo_request) begin
                    next_state = brew_pkg::settings;
                end
            end
            brew_pkg::size_select: begin
                if (pressed.select) begin
                    next_state = brew_pkg::confirm;
                end else if (pressed.cancel) begin
                    next_state = brew_pkg::drink_select;
                end else if (combo_request) begin
                    next_state = brew_pkg::settings;
                end
            end
            brew_pkg::confirm: begin
                // Invalid recipe keeps us here on select
                if (pressed.select && status.recipe_valid) begin
                    next_state = brew_pkg::brewing;
                end else if (pressed.cancel) begin
                    next_state = brew_pkg::size_select;
                end else if (combo_request) begin
                    next_state = brew_pkg::settings;
                end
            end
            brew_pkg::brewing: begin
                if (!status.brewing_active) begin
                    next_state = brew_pkg::complete;
                end else if (pressed.cancel) begin
                    next_state = brew_pkg::splash;
                end
            end
            brew_pkg::complete: begin
                if (any_press) begin
                    next_state = brew_pkg::splash;
                end
            end
            brew_pkg::error: begin
                // Fault gone and coffee back
                if (!status.error_present && status.can_make_coffee) begin
                    next_state = brew_pkg::splash;
                end else if (pressed.cancel) begin
                    next_state = brew_pkg::splash;
                end else if (combo_request) begin
                    next_state = brew_pkg::settings;
                end
            end
            brew_pkg::settings: begin
                if (pressed.cancel) begin
                    next_state = brew_pkg::splash;
                end
            end
            default: begin
                next_state = brew_pkg::splash;
            end
        endcase
    end

    // ==================================================
    // Outputs
    // ==================================================

    // Wheel enables follow the page on show
    assign bin_active   = (menu_state == brew_pkg::coffee_select);
    assign drink_active = (menu_state == brew_pkg::drink_select);
    assign size_active  = (menu_state == brew_pkg::size_select);

    // Pulses line up with the first cycle of the new state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_brewing  <= 1'b0;
            enter_settings <= 1'b0;
        end else begin
            start_brewing  <= (next_state == brew_pkg::brewing) &&
                              (menu_state != brew_pkg::brewing);
            enter_settings <= (next_state == brew_pkg::settings) &&
                              (menu_state != brew_pkg::settings);
        end
    end

endmodule

// ==== design/menu_navigator.sv ====
/*
 * Coffee machine menu navigator, top level.
 * Debounces the front-panel buttons, detects the settings combo, runs
 * the menu state machine and keeps the bin, drink and size choices.
 */

`timescale 1ns/1ps

module menu_navigator #(
    parameter int DEBOUNCE_CYCLES = 1_000_000,
    parameter int COMBO_CYCLES    = 100_000_000
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  ui_pkg::btn_set_t          buttons,
    input  brew_pkg::machine_status_t status,
    output brew_pkg::menu_state_e     menu_state,
    output brew_pkg::brew_sel_t       selection,
    output logic                      start_brewing,
    output logic                      enter_settings
);

    ui_pkg::btn_set_t    held;
    ui_pkg::btn_set_t    pressed;
    logic                combo_request;
    logic                bin_active;
    logic                drink_active;
    logic                size_active;
    brew_pkg::item_idx_t bin_value;
    brew_pkg::item_idx_t drink_value;
    brew_pkg::item_idx_t size_value;

    // ==================================================
    // Buttons and combo
    // ==================================================

    button_frontend #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) i_frontend (
        .clk     (clk),
        .rst_n   (rst_n),
        .raw     (buttons),
        .held    (held),
        .pressed (pressed)
    );

    settings_combo_detector #(.COMBO_CYCLES(COMBO_CYCLES)) i_combo (
        .clk           (clk),
        .rst_n         (rst_n),
        .held          (held),
        .combo_request (combo_request)
    );

    // ==================================================
    // Menu control
    // ==================================================

    menu_fsm i_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .pressed        (pressed),
        .combo_request  (combo_request),
        .status         (status),
        .menu_state     (menu_state),
        .bin_active     (bin_active),
        .drink_active   (drink_active),
        .size_active    (size_active),
        .start_brewing  (start_brewing),
        .enter_settings (enter_settings)
    );

    // One wheel per choice page
    selection_wheel #(
        .NUM_ITEMS  (brew_pkg::NUM_COFFEE_BINS),
        .RESET_ITEM (brew_pkg::DEFAULT_BIN)
    ) i_bin_wheel (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (bin_active),
        .step_left  (pressed.left),
        .step_right (pressed.right),
        .value      (bin_value)
    );

    selection_wheel #(
        .NUM_ITEMS  (brew_pkg::NUM_DRINKS),
        .RESET_ITEM (brew_pkg::DEFAULT_DRINK)
    ) i_drink_wheel (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (drink_active),
        .step_left  (pressed.left),
        .step_right (pressed.right),
        .value      (drink_value)
    );

    selection_wheel #(
        .NUM_ITEMS  (brew_pkg::NUM_SIZES),
        .RESET_ITEM (brew_pkg::DEFAULT_SIZE)
    ) i_size_wheel (
        .clk        (clk),
        .rst_n      (rst_n),
        .active     (size_active),
        .step_left  (pressed.left),
        .step_right (pressed.right),
        .value      (size_value)
    );

    // Size never exceeds 2, two bits suffice
    assign selection.bin   = bin_value;
    assign selection.drink = drink_value;
    assign selection.size  = size_value[1:0];

endmodule

// ==== test/menu_navigator_asserts.sv ====
/*
 * Bound checks on the menu navigator outputs.
 * Pulses last one cycle and match the state they announce, and the
 * selection never leaves its range.
 */

`timescale 1ns/1ps

module menu_navigator_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input brew_pkg::menu_state_e menu_state,
    input brew_pkg::brew_sel_t   selection,
    input logic                  start_brewing,
    input logic                  enter_settings
);

    // Number of failed checks
    int fail_count = 0;

    // Pulses are single-cycle
    a_start_once: assert property (@(posedge clk) disable iff (!rst_n)
        start_brewing |=> !start_brewing)
        else begin
            fail_count++;
            $error("start_brewing high for two cycles in a row");
        end

    a_settings_once: assert property (@(posedge clk) disable iff (!rst_n)
        enter_settings |=> !enter_settings)
        else begin
            fail_count++;
            $error("enter_settings high for two cycles in a row");
        end

    // Pulse comes with its state
    a_start_state: assert property (@(posedge clk) disable iff (!rst_n)
        start_brewing |-> menu_state == brew_pkg::brewing)
        else begin
            fail_count++;
            $error("start_brewing high outside the brewing state");
        end

    a_sel_range: assert property (@(posedge clk) disable iff (!rst_n)
        selection.bin < brew_pkg::NUM_COFFEE_BINS && selection.drink < brew_pkg::NUM_DRINKS
        && selection.size < brew_pkg::NUM_SIZES)
        else begin
            fail_count++;
            $error("selection field out of range");
        end

endmodule

bind menu_navigator menu_navigator_asserts i_asserts (
    .clk            (clk),
    .rst_n          (rst_n),
    .menu_state     (menu_state),
    .selection      (selection),
    .start_brewing  (start_brewing),
    .enter_settings (enter_settings)
);

// ==== test/tb_menu_navigator.sv ====
/*
 * Testbench for the coffee machine menu navigator.
 * A directed walk through the menu is followed by seeded random
 * button, glitch, combo and status actions. A reference model
 * predicts state, selection and pulse counts after every action.
 */

`timescale 1ns/1ps

module tb_menu_navigator;

    localparam int DEBOUNCE     = 4;
    localparam int COMBO        = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_DIRECTED = 40;
    localparam int NUM_RANDOM   = 300;
    localparam int WATCHDOG     = (NUM_DIRECTED + NUM_RANDOM) * 100 + RESET_CYCLES;

    // Hold lengths in cycles
    localparam int TAP_HOLD   = 8;
    localparam int LONG_HOLD  = COMBO + 20;
    localparam int SHORT_HOLD = COMBO / 2;

    // Field order is cancel, left, right, select
    localparam ui_pkg::btn_set_t BTN_CANCEL = 4'b1000;
    localparam ui_pkg::btn_set_t BTN_LEFT   = 4'b0100;
    localparam ui_pkg::btn_set_t BTN_RIGHT  = 4'b0010;
    localparam ui_pkg::btn_set_t BTN_SELECT = 4'b0001;
    localparam ui_pkg::btn_set_t BTN_COMBO  = 4'b0111;

    logic                      clk = 1'b0;
    logic                      rst_n;
    ui_pkg::btn_set_t          buttons;
    brew_pkg::machine_status_t status;
    brew_pkg::menu_state_e     menu_state;
    brew_pkg::brew_sel_t       selection;
    logic                      start_brewing;
    logic                      enter_settings;

    // Reference model
    brew_pkg::menu_state_e exp_state;
    int                    exp_bin;
    int                    exp_drink;
    int                    exp_size;
    int                    exp_starts   = 0;
    int                    exp_settings = 0;
    int                    seen_starts   = 0;
    int                    seen_settings = 0;
    integer                seed = 32'ha28f9f6d;

    menu_navigator #(
        .DEBOUNCE_CYCLES (DEBOUNCE),
        .COMBO_CYCLES    (COMBO)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .buttons        (buttons),
        .status         (status),
        .menu_state     (menu_state),
        .selection      (selection),
        .start_brewing  (start_brewing),
        .enter_settings (enter_settings)
    );

    always #4 clk = ~clk;

    // Count pulses, one per high cycle
    always @(posedge clk) begin
        if (start_brewing) seen_starts++;
        if (enter_settings) seen_settings++;
    end

    // ==================================================
    // Reference model
    // ==================================================

    function automatic brew_pkg::menu_state_e predict_state(
        input brew_pkg::menu_state_e     s,
        input ui_pkg::btn_set_t          p,
        input logic                      combo,
        input brew_pkg::machine_status_t st
    );
        brew_pkg::menu_state_e n;
        logic                  any;
        any = |p;
        n   = s;
        case (s)
            brew_pkg::splash: begin
                if (any) n = brew_pkg::check_errors;
                else if (combo) n = brew_pkg::settings;
            end
            brew_pkg::check_errors: begin
                if (st.error_present) n = brew_pkg::error;
                else if (st.system_ready && st.can_make_coffee) n = brew_pkg::coffee_select;
                else if (!st.can_make_coffee) n = brew_pkg::error;
            end
            brew_pkg::coffee_select: begin
                if (p.select) n = brew_pkg::drink_select;
                else if (p.cancel) n = brew_pkg::splash;
                else if (combo) n = brew_pkg::settings;
            end
            brew_pkg::drink_select: begin
                if (p.select) n = brew_pkg::size_select;
                else if (p.cancel) n = brew_pkg::coffee_select;
                else if (combo) n = brew_pkg::settings;
            end
            brew_pkg::size_select: begin
                if (p.select) n = brew_pkg::confirm;
                else if (p.cancel) n = brew_pkg::drink_select;
                else if (combo) n = brew_pkg::settings;
            end
            brew_pkg::confirm: begin
                if (p.select && st.recipe_valid) n = brew_pkg::brewing;
                else if (p.cancel) n = brew_pkg::size_select;
                else if (combo) n = brew_pkg::settings;
            end
            brew_pkg::brewing: begin
                if (!st.brewing_active) n = brew_pkg::complete;
                else if (p.cancel) n = brew_pkg::splash;
            end
            brew_pkg::complete: begin
                if (any) n = brew_pkg::splash;
            end
            brew_pkg::error: begin
                if (!st.error_present && st.can_make_coffee) n = brew_pkg::splash;
                else if (p.cancel) n = brew_pkg::splash;
                else if (combo) n = brew_pkg::settings;
            end
            brew_pkg::settings: begin
                if (p.cancel) n = brew_pkg::splash;
            end
            default: n = brew_pkg::splash;
        endcase
        return n;
    endfunction

    // Left wins over right, wrap over the entry count
    function automatic int wheel_step(input int v, input ui_pkg::btn_set_t p, input int count);
        if (p.left) return (v + count - 1) % count;
        if (p.right) return (v + 1) % count;
        return v;
    endfunction

    // New expected state, with the pulse it announces
    task automatic move_to(input brew_pkg::menu_state_e n);
        if (n == brew_pkg::brewing && exp_state != brew_pkg::brewing) exp_starts++;
        if (n == brew_pkg::settings && exp_state != brew_pkg::settings) exp_settings++;
        exp_state = n;
    endtask

    // Status-only moves until nothing changes
    task automatic settle_model();
        repeat (4) move_to(predict_state(exp_state, '0, 1'b0, status));
    endtask

    // One press event, wheels see the page before the move
    task automatic apply_press(input ui_pkg::btn_set_t p);
        case (exp_state)
            brew_pkg::coffee_select: exp_bin = wheel_step(exp_bin, p, brew_pkg::NUM_COFFEE_BINS);
            brew_pkg::drink_select:  exp_drink = wheel_step(exp_drink, p, brew_pkg::NUM_DRINKS);
            brew_pkg::size_select:   exp_size = wheel_step(exp_size, p, brew_pkg::NUM_SIZES);
            default: ;
        endcase
        move_to(predict_state(exp_state, p, 1'b0, status));
        settle_model();
    endtask

    // ==================================================
    // Checks
    // ==================================================

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
            $display("sim failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs();
        compare("menu_state", exp_state, menu_state);
        compare("selection.bin", exp_bin, selection.bin);
        compare("selection.drink", exp_drink, selection.drink);
        compare("selection.size", exp_size, selection.size);
        compare("start_brewing count", exp_starts, seen_starts);
        compare("enter_settings count", exp_settings, seen_settings);
    endtask

    // ==================================================
    // Actions, each ends idle at a falling edge
    // ==================================================

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic press_button(input ui_pkg::btn_set_t b);
        buttons = b;
        idle(TAP_HOLD);
        buttons = '0;
        idle(TAP_HOLD);
        apply_press(b);
        check_outputs();
    endtask

    // Shorter than the debounce length, so no event
    task automatic inject_glitch(input ui_pkg::btn_set_t b, input int len);
        buttons = b;
        idle(len);
        buttons = '0;
        idle(TAP_HOLD);
        check_outputs();
    endtask

    task automatic hold_combo(input int hold);
        buttons = BTN_COMBO;
        idle(hold);
        buttons = '0;
        idle(TAP_HOLD);
        // All three presses land in the same cycle
        apply_press(BTN_COMBO);
        if (hold == LONG_HOLD) begin
            move_to(predict_state(exp_state, '0, 1'b1, status));
            settle_model();
        end
        check_outputs();
    endtask

    task automatic change_status(input brew_pkg::machine_status_t s);
        status = s;
        idle(TAP_HOLD);
        settle_model();
        check_outputs();
    endtask

    function automatic brew_pkg::machine_status_t make_status(
        input logic ready, input logic brew, input logic err, input logic recipe, input logic coffee
    );
        brew_pkg::machine_status_t s;
        s.system_ready    = ready;
        s.brewing_active  = brew;
        s.error_present   = err;
        s.recipe_valid    = recipe;
        s.can_make_coffee = coffee;
        return s;
    endfunction

    task automatic random_action();
        int                        kind;
        int                        pick;
        ui_pkg::btn_set_t          b;
        brew_pkg::machine_status_t s;
        kind = {$random(seed)} % 10;
        pick = {$random(seed)} % 6;
        // Select weighted up so walks get deep
        case (pick)
            0:       b = BTN_CANCEL;
            1:       b = BTN_LEFT;
            2:       b = BTN_RIGHT;
            default: b = BTN_SELECT;
        endcase
        if (kind < 6) begin
            press_button(b);
        end else if (kind < 7) begin
            inject_glitch(b, 1 + {$random(seed)} % (DEBOUNCE - 1));
        end else if (kind < 8) begin
            hold_combo(({$random(seed)} % 2 == 0) ? LONG_HOLD : SHORT_HOLD);
        end else begin
            s = make_status({$random(seed)} % 8 != 0, {$random(seed)} % 2 == 0,
                            {$random(seed)} % 6 == 0, {$random(seed)} % 4 != 0,
                            {$random(seed)} % 5 != 0);
            change_status(s);
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        rst_n        = 1'b0;
        buttons      = '0;
        status       = make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b1);
        exp_state    = brew_pkg::splash;
        exp_bin      = brew_pkg::DEFAULT_BIN;
        exp_drink    = brew_pkg::DEFAULT_DRINK;
        exp_size     = brew_pkg::DEFAULT_SIZE;
        idle(RESET_CYCLES);
        rst_n = 1'b1;
        idle(2);
        check_outputs();

        // Glitches leave the defaults alone
        inject_glitch(BTN_CANCEL, 1);
        inject_glitch(BTN_LEFT, 2);
        inject_glitch(BTN_RIGHT, 3);
        inject_glitch(BTN_SELECT, DEBOUNCE - 1);

        // Full walk through every page
        press_button(BTN_SELECT);
        press_button(BTN_RIGHT);
        press_button(BTN_RIGHT);
        press_button(BTN_LEFT);
        press_button(BTN_SELECT);
        press_button(BTN_LEFT);
        press_button(BTN_RIGHT);
        press_button(BTN_RIGHT);
        press_button(BTN_SELECT);
        press_button(BTN_RIGHT);
        press_button(BTN_RIGHT);
        press_button(BTN_CANCEL);
        press_button(BTN_SELECT);
        press_button(BTN_SELECT);
        press_button(BTN_LEFT);
        change_status(make_status(1'b1, 1'b1, 1'b0, 1'b1, 1'b1));
        press_button(BTN_SELECT);
        change_status(make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
        press_button(BTN_RIGHT);

        // Fault and empty bin paths
        change_status(make_status(1'b1, 1'b0, 1'b1, 1'b1, 1'b1));
        press_button(BTN_SELECT);
        change_status(make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b1));
        change_status(make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
        press_button(BTN_SELECT);
        press_button(BTN_CANCEL);
        change_status(make_status(1'b1, 1'b0, 1'b0, 1'b1, 1'b1));

        // Settings combo, long and short
        hold_combo(LONG_HOLD);
        press_button(BTN_CANCEL);
        press_button(BTN_SELECT);
        press_button(BTN_SELECT);
        hold_combo(SHORT_HOLD);
        hold_combo(LONG_HOLD);
        press_button(BTN_CANCEL);

        repeat (NUM_RANDOM) random_action();

        idle(2);
        if (i_dut.i_asserts.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("A bound assertion on the DUT outputs failed during the run");
            $display("sim failed");
            $fatal(1, "assertion failure");
        end
    end

    // Stop early once a bound assertion has fired
    always @(negedge clk) begin
        if (i_dut.i_asserts.fail_count != 0) begin
            $display("A bound assertion on the DUT outputs failed");
            $display("sim failed");
            $fatal(1, "assertion failure");
        end
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("The test sequence did not finish before the watchdog expired");
        $display("sim failed");
        $fatal(1, "timeout");
    end

endmodule

// ==== project.f ====
design/ui_pkg.sv
design/brew_pkg.sv
design/button_debouncer.sv
design/button_frontend.sv
design/settings_combo_detector.sv
design/selection_wheel.sv
design/menu_fsm.sv
design/menu_navigator.sv
test/menu_navigator_asserts.sv
test/tb_menu_navigator.sv

// ==== Bender.yml ====
package:
  name: menu_navigator

sources:
  - design/ui_pkg.sv
  - design/brew_pkg.sv
  - design/button_debouncer.sv
  - design/button_frontend.sv
  - design/settings_combo_detector.sv
  - design/selection_wheel.sv
  - design/menu_fsm.sv
  - design/menu_navigator.sv
  - target: test
    files:
      - test/menu_navigator_asserts.sv
      - test/tb_menu_navigator.sv
